//--- src.f
+incdir+common
common/bp_pkg.sv
common/cb_bp_itf.sv
hw/branch_predictor/btb.sv
hw/branch_predictor/bimodal_bht.sv
hw/branch_predictor/fetch_redirect.sv
hw/branch_predictor_top.sv
verification/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f src.f --top-module tb_branch_predictor -o tb_branch_predictor
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_branch_predictor > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

exit 0

//--- verification/tb_branch_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module tb_branch_predictor
import bp_pkg::*;
();
    localparam int IF_W          = `BP_IF_WIDTH;
    localparam int SLOT_W        = $clog2(IF_W);
    localparam int BLK_BYTES     = IF_W * 4;
    localparam int DEPTH         = `BP_BTB_DEPTH;
    localparam int RESET_CYCLES  = 2;
    localparam int RANDOM_CYCLES = 400;
    // two resets, tests 1 to 5, one closing idle cycle.
    localparam int DIRECTED_CYCLES = 2 * RESET_CYCLES + 1 + 2 + 4 + 8 + 18 + 3 + 4 + 1;
    localparam int MAX_CYCLES      = DIRECTED_CYCLES + RANDOM_CYCLES + 100;

    logic                   clk;
    logic                   rst;
    logic [31:0]            fetch_pc;
    logic                   update_en;
    logic                   branch_taken;
    br_op_t                 fu_opcode;
    logic [31:0]            update_pc;
    logic [31:0]            update_target;
    logic [IF_W-1:0][31:0]  predict_target;
    logic [IF_W-1:0]        slot_taken;
    logic [31:0]            next_pc;
    logic                   redirect;
    logic [SLOT_W-1:0]      redirect_slot;

    // reference model state.
    btb_entry_t             m_tbl [2][DEPTH]; // 0 branches, 1 jumps.
    logic [`BP_BTB_IDX-1:0] m_rr [2];
    logic [1:0]             m_ctr [`BP_BHT_DEPTH];

    string  test_name;
    integer seed;
    int     cycle_cnt;

    branch_predictor_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .fetch_pc       (fetch_pc),
        .update_en      (update_en),
        .branch_taken   (branch_taken),
        .fu_opcode      (fu_opcode),
        .update_pc      (update_pc),
        .update_target  (update_target),
        .predict_target (predict_target),
        .slot_taken     (slot_taken),
        .next_pc        (next_pc),
        .redirect       (redirect),
        .redirect_slot  (redirect_slot)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [31:0] block_base(input logic [31:0] a);
        return (a / BLK_BYTES) * BLK_BYTES;
    endfunction

    function automatic logic [IF_W-1:0] ref_slot_taken(input logic [31:0] fpc);
        logic [IF_W-1:0] r;
        logic [31:0]     spc;
        for (int s = 0; s < IF_W; s++) begin
            spc  = block_base(fpc) + 32'(s) * 32'd4;
            r[s] = m_ctr[spc[`BP_BHT_IDX+1:2]][1]; // upper half means taken.
        end
        return r;
    endfunction

    // {hit, target} for one slot.
    function automatic logic [32:0] ref_slot(input logic [31:0] fpc, input int s);
        logic [31:0]     spc;
        logic [IF_W-1:0] tk;
        spc = block_base(fpc) + 32'(s) * 32'd4;
        tk  = ref_slot_taken(fpc);
        for (int i = 0; i < DEPTH; i++) begin
            if (m_tbl[0][i].valid && m_tbl[0][i].pc == spc && tk[s]) begin
                return {1'b1, m_tbl[0][i].target_address};
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (m_tbl[1][i].valid && m_tbl[1][i].pc == spc) begin
                return {1'b1, m_tbl[1][i].target_address};
            end
        end
        return {1'b0, spc + 32'd4};
    endfunction

    task automatic model_update(input br_op_t op, input logic taken,
                                input logic [31:0] pc, input logic [31:0] tgt);
        logic [`BP_BHT_IDX-1:0] idx;
        int                     t;
        int                     hit_i;
        int                     free_i;
        int                     wr_i;
        idx = pc[`BP_BHT_IDX+1:2];
        if (op == BR_COND) begin
            if (taken && m_ctr[idx] != 2'b11) begin
                m_ctr[idx] = m_ctr[idx] + 2'b01;
            end else if (!taken && m_ctr[idx] != 2'b00) begin
                m_ctr[idx] = m_ctr[idx] - 2'b01;
            end
        end
        if (taken) begin
            t      = (op == BR_COND) ? 0 : 1;
            hit_i  = -1;
            free_i = -1;
            for (int i = 0; i < DEPTH; i++) begin
                if (m_tbl[t][i].valid && m_tbl[t][i].pc == pc) begin
                    hit_i = i;
                end
                if (!m_tbl[t][i].valid) begin
                    free_i = i; // last one seen is the highest.
                end
            end
            if (hit_i >= 0) begin
                wr_i = hit_i;
            end else if (free_i >= 0) begin
                wr_i = free_i;
            end else begin
                wr_i    = int'(m_rr[t]);
                m_rr[t] = m_rr[t] + 1'b1;
            end
            m_tbl[t][wr_i] = '{valid: 1'b1, target_address: tgt, pc: pc};
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < 2; t++) begin
                m_rr[t] = '0;
                for (int i = 0; i < DEPTH; i++) begin
                    m_tbl[t][i] = '0;
                end
            end
            for (int i = 0; i < `BP_BHT_DEPTH; i++) begin
                m_ctr[i] = 2'b01;
            end
        end else if (update_en) begin
            model_update(fu_opcode, branch_taken, update_pc, update_target);
        end
    end

    task automatic compare_outputs();
        logic [IF_W-1:0][31:0] exp_tgt;
        logic [IF_W-1:0]       exp_hit;
        logic [32:0]           r;
        logic                  exp_redir;
        logic [SLOT_W-1:0]     exp_slot;
        logic [31:0]           exp_next;
        exp_redir = 1'b0;
        exp_slot  = '0;
        exp_next  = block_base(fetch_pc) + 32'(BLK_BYTES);
        for (int s = 0; s < IF_W; s++) begin
            r          = ref_slot(fetch_pc, s);
            exp_hit[s] = r[32];
            exp_tgt[s] = r[31:0];
            if (exp_hit[s] && !exp_redir) begin
                exp_redir = 1'b1;
                exp_slot  = SLOT_W'(s);
                exp_next  = r[31:0];
            end
        end
        check_value("slot_taken", 64'(ref_slot_taken(fetch_pc)), 64'(slot_taken));
        check_value("predict_target", 64'(exp_tgt), 64'(predict_target));
        check_value("redirect", 64'(exp_redir), 64'(redirect));
        check_value("redirect_slot", 64'(exp_slot), 64'(redirect_slot));
        check_value("next_pc", 64'(exp_next), 64'(next_pc));
    endtask

    // outputs are settled well before the rising edge.
    initial begin
        forever begin
            @(negedge clk);
            #4;
            if (!rst) begin
                compare_outputs();
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt <= MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
        $display("Done: errors found");
        $fatal(1, "simulation stopped by timeout");
    end

    task automatic drive_cycle(input logic [31:0] fpc, input logic en, input br_op_t op,
                               input logic taken, input logic [31:0] upc,
                               input logic [31:0] utgt);
        @(negedge clk);
        fetch_pc      = fpc;
        update_en     = en;
        fu_opcode     = op;
        branch_taken  = taken;
        update_pc     = upc;
        update_target = utgt;
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst       = 1'b1;
        update_en = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    // fetch only, then hand-derived checks.
    task automatic expect_fetch(input logic [31:0] fpc, input logic exp_redir,
                                input logic [SLOT_W-1:0] exp_slot,
                                input logic [31:0] exp_next);
        drive_cycle(fpc, 1'b0, BR_COND, 1'b0, 32'h0, 32'h0);
        #2;
        check_value("redirect", 64'(exp_redir), 64'(redirect));
        check_value("redirect_slot", 64'(exp_slot), 64'(redirect_slot));
        check_value("next_pc", 64'(exp_next), 64'(next_pc));
    endtask

    initial begin
        logic [31:0] rnd_fetch;
        logic [31:0] rnd_pc;
        logic [31:0] rnd_tgt;
        logic        rnd_en;
        logic        rnd_taken;
        int          op_sel;
        br_op_t      rnd_op;
        seed          = 56;
        rst           = 1'b1;
        fetch_pc      = '0;
        update_en     = 1'b0;
        branch_taken  = 1'b0;
        fu_opcode     = BR_COND;
        update_pc     = '0;
        update_target = '0;
        test_name     = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "after_reset";
        expect_fetch(32'h100, 1'b0, '0, 32'h108);
        expect_fetch(32'h10c, 1'b0, '0, 32'h110);

        test_name = "jump_insert";
        drive_cycle(32'h200, 1'b1, BR_JAL, 1'b1, 32'h204, 32'h800);
        expect_fetch(32'h200, 1'b1, 1'b1, 32'h800);
        drive_cycle(32'h200, 1'b1, BR_JALR, 1'b1, 32'h204, 32'h900);
        expect_fetch(32'h200, 1'b1, 1'b1, 32'h900);

        // counter goes 1, 0, 1, 2, then back to 1.
        test_name = "cond_branch";
        drive_cycle(32'h300, 1'b1, BR_COND, 1'b0, 32'h300, 32'h40);
        expect_fetch(32'h300, 1'b0, '0, 32'h308);
        drive_cycle(32'h300, 1'b1, BR_COND, 1'b1, 32'h300, 32'h40);
        expect_fetch(32'h300, 1'b0, '0, 32'h308);
        drive_cycle(32'h300, 1'b1, BR_COND, 1'b1, 32'h300, 32'h40);
        expect_fetch(32'h300, 1'b1, '0, 32'h40);
        drive_cycle(32'h300, 1'b1, BR_COND, 1'b0, 32'h300, 32'h40);
        expect_fetch(32'h300, 1'b0, '0, 32'h308);

        // entries fill from 7 down, so the eighth branch sits in entry 0.
        test_name = "replacement";
        reset_dut();
        for (int k = 0; k < 9; k++) begin
            repeat (2) begin
                drive_cycle(32'h1000 + 32'(16 * k), 1'b1, BR_COND, 1'b1,
                            32'h1000 + 32'(16 * k), 32'h8000 + 32'(256 * k));
            end
        end
        expect_fetch(32'h1070, 1'b0, '0, 32'h1078);
        expect_fetch(32'h1080, 1'b1, '0, 32'h8800);
        expect_fetch(32'h1000, 1'b1, '0, 32'h8000);

        test_name = "slot_priority";
        drive_cycle(32'h500, 1'b1, BR_JAL, 1'b1, 32'h504, 32'hb00);
        drive_cycle(32'h500, 1'b1, BR_JAL, 1'b1, 32'h500, 32'ha00);
        expect_fetch(32'h500, 1'b1, '0, 32'ha00);
        expect_fetch(32'h504, 1'b1, '0, 32'ha00);

        // small pc pool keeps hits and replacements frequent.
        test_name = "random_mix";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd_fetch = 32'h1000 + (32'($random(seed)) & 32'h7f);
            rnd_pc    = 32'h1000 + ((32'($random(seed)) & 32'h1f) << 2);
            rnd_tgt   = 32'h2000 + ((32'($random(seed)) & 32'hff) << 2);
            rnd_en    = 1'($random(seed));
            rnd_taken = 1'($random(seed));
            op_sel    = int'($unsigned($random(seed)) % 3);
            if (op_sel == 0) begin
                rnd_op = BR_COND;
            end else if (op_sel == 1) begin
                rnd_op = BR_JAL;
            end else begin
                rnd_op = BR_JALR;
            end
            drive_cycle(rnd_fetch, rnd_en, rnd_op, rnd_taken, rnd_pc, rnd_tgt);
        end

        drive_cycle(32'h100, 1'b0, BR_COND, 1'b0, 32'h0, 32'h0);
        #6;
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- hw/branch_predictor_top.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor_top
import bp_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [31:0]                          fetch_pc,

    // commit side training.
    input  logic                                 update_en,
    input  logic                                 branch_taken,
    input  br_op_t                               fu_opcode,
    input  logic [31:0]                          update_pc,
    input  logic [31:0]                          update_target,

    output logic [`BP_IF_WIDTH-1:0][31:0]        predict_target,
    output logic [`BP_IF_WIDTH-1:0]              slot_taken,
    output logic [31:0]                          next_pc,
    output logic                                 redirect,
    output logic [$clog2(`BP_IF_WIDTH)-1:0]      redirect_slot
);
    logic [`BP_IF_WIDTH-1:0] predict_hit;

    cb_bp_itf upd_if ();

    assign upd_if.update_en      = update_en;
    assign upd_if.branch_taken   = branch_taken;
    assign upd_if.fu_opcode      = fu_opcode;
    assign upd_if.pc             = update_pc;
    assign upd_if.target_address = update_target;

    bimodal_bht i_bht (
        .clk        (clk),
        .rst        (rst),
        .from_cb    (upd_if.bp),
        .fetch_pc   (fetch_pc),
        .slot_taken (slot_taken)
    );

    btb i_btb (
        .clk            (clk),
        .rst            (rst),
        .from_cb        (upd_if.bp),
        .fetch_pc       (fetch_pc),
        .slot_taken     (slot_taken),
        .predict_target (predict_target),
        .predict_hit    (predict_hit)
    );

    fetch_redirect i_redirect (
        .fetch_pc       (fetch_pc),
        .predict_target (predict_target),
        .predict_hit    (predict_hit),
        .next_pc        (next_pc),
        .redirect       (redirect),
        .redirect_slot  (redirect_slot)
    );

endmodule

//--- hw/branch_predictor/fetch_redirect.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module fetch_redirect (
    input  logic [31:0]                          fetch_pc,
    input  logic [`BP_IF_WIDTH-1:0][31:0]        predict_target,
    input  logic [`BP_IF_WIDTH-1:0]              predict_hit,
    output logic [31:0]                          next_pc,
    output logic                                 redirect,
    output logic [$clog2(`BP_IF_WIDTH)-1:0]      redirect_slot
);
    localparam int IF_W      = `BP_IF_WIDTH;
    localparam int SLOT_W    = $clog2(IF_W);
    localparam int BLK_BYTES = IF_W * 4;

    logic [31:0] blk_base;

    assign blk_base = fetch_pc & ~32'(BLK_BYTES - 1);
    assign redirect = |predict_hit;

    // first taken slot in program order wins.
    always_comb begin
        redirect_slot = '0;
        next_pc       = blk_base + 32'(BLK_BYTES); // next sequential block.
        for (int s = IF_W - 1; s >= 0; s--) begin
            if (predict_hit[s]) begin
                redirect_slot = SLOT_W'(s);
                next_pc       = predict_target[s];
            end
        end
    end

endmodule

//--- hw/branch_predictor/bimodal_bht.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module bimodal_bht
import bp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    cb_bp_itf.bp                    from_cb,

    input  logic [31:0]             fetch_pc,
    output logic [`BP_IF_WIDTH-1:0] slot_taken
);
    localparam int IF_W      = `BP_IF_WIDTH;
    localparam int DEPTH     = `BP_BHT_DEPTH;
    localparam int IDX_W     = `BP_BHT_IDX;
    localparam int BLK_BYTES = IF_W * 4;

    logic [1:0]       ctr [DEPTH];
    logic [IDX_W-1:0] upd_idx;
    logic [1:0]       upd_ctr;
    logic [31:0]      blk_base;

    assign upd_idx  = from_cb.pc[IDX_W+1:2];
    assign upd_ctr  = ctr[upd_idx];
    assign blk_base = fetch_pc & ~32'(BLK_BYTES - 1);

    // jumps leave the counters alone.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr[i] <= 2'b01; // weakly not-taken.
            end
        end else if (from_cb.update_en && from_cb.fu_opcode == BR_COND) begin
            if (from_cb.branch_taken) begin
                if (upd_ctr != 2'b11) begin
                    ctr[upd_idx] <= upd_ctr + 2'b01;
                end
            end else if (upd_ctr != 2'b00) begin
                ctr[upd_idx] <= upd_ctr - 2'b01;
            end
        end
    end

    always_comb begin
        logic [31:0] slot_pc;
        for (int s = 0; s < IF_W; s++) begin
            slot_pc       = blk_base + 32'(s) * 32'd4;
            slot_taken[s] = ctr[slot_pc[IDX_W+1:2]][1]; // msb is the call.
        end
    end

    // counters come out of reset defined, and training keeps them so.
    a_taken_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(slot_taken))
        else $error("bimodal_bht: slot_taken unknown");

endmodule

//--- hw/branch_predictor/btb.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module btb
import bp_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,

    cb_bp_itf.bp                          from_cb,

    input  logic [31:0]                   fetch_pc,
    input  logic [`BP_IF_WIDTH-1:0]       slot_taken,
    output logic [`BP_IF_WIDTH-1:0][31:0] predict_target,
    output logic [`BP_IF_WIDTH-1:0]       predict_hit
);
    localparam int IF_W      = `BP_IF_WIDTH;
    localparam int DEPTH     = `BP_BTB_DEPTH;
    localparam int IDX_W     = `BP_BTB_IDX;
    localparam int BLK_BYTES = IF_W * 4;
    localparam int NUM_TBL   = 2;
    localparam int BR_TBL    = 0;
    localparam int J_TBL     = 1;

    // table 0 holds conditional branches, table 1 jumps.
    btb_entry_t       tbl [NUM_TBL][DEPTH];
    logic [IDX_W-1:0] rr_cnt [NUM_TBL];

    logic             train;
    logic             upd_tbl;
    logic             match_found;
    logic             free_found;
    logic [IDX_W-1:0] match_idx;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [31:0]      blk_base;
    logic             dup_pc;

    assign train   = from_cb.update_en && from_cb.branch_taken; // only taken ones.
    assign upd_tbl = (from_cb.fu_opcode != BR_COND);
    assign blk_base = fetch_pc & ~32'(BLK_BYTES - 1);

    // victim search in the selected table.
    always_comb begin
        match_found = 1'b0;
        free_found  = 1'b0;
        match_idx   = '0;
        free_idx    = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (tbl[upd_tbl][i].valid && tbl[upd_tbl][i].pc == from_cb.pc) begin
                match_found = 1'b1;
                match_idx   = IDX_W'(i);
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (!tbl[upd_tbl][i].valid) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i); // highest invalid wins.
            end
        end
    end

    always_comb begin
        if (match_found) begin
            wr_idx = match_idx;
        end else if (free_found) begin
            wr_idx = free_idx;
        end else begin
            wr_idx = rr_cnt[upd_tbl];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < NUM_TBL; t++) begin
                rr_cnt[t] <= '0;
                for (int i = 0; i < DEPTH; i++) begin
                    tbl[t][i].valid <= 1'b0;
                end
            end
        end else if (train) begin
            tbl[upd_tbl][wr_idx] <= '{
                valid:          1'b1,
                target_address: from_cb.target_address,
                pc:             from_cb.pc
            };
            if (!match_found && !free_found) begin
                rr_cnt[upd_tbl] <= rr_cnt[upd_tbl] + 1'b1;
            end
        end
    end

    // per-slot lookup.
    // jump table first, then branch table, each scanned downward,
    // so the branch table and the lowest index take priority.
    always_comb begin
        logic [31:0] slot_pc;
        for (int s = 0; s < IF_W; s++) begin
            slot_pc           = blk_base + 32'(s) * 32'd4;
            predict_hit[s]    = 1'b0;
            predict_target[s] = slot_pc + 32'd4; // fall through.
            for (int t = J_TBL; t >= BR_TBL; t--) begin
                for (int i = DEPTH - 1; i >= 0; i--) begin
                    if (tbl[t][i].valid && tbl[t][i].pc == slot_pc &&
                        (t == J_TBL || slot_taken[s])) begin
                        predict_hit[s]    = 1'b1;
                        predict_target[s] = tbl[t][i].target_address;
                    end
                end
            end
        end
    end

    always_comb begin
        dup_pc = 1'b0;
        for (int t = 0; t < NUM_TBL; t++) begin
            for (int i = 0; i < DEPTH; i++) begin
                for (int j = i + 1; j < DEPTH; j++) begin
                    if (tbl[t][i].valid && tbl[t][j].valid &&
                        tbl[t][i].pc == tbl[t][j].pc) begin
                        dup_pc = 1'b1;
                    end
                end
            end
        end
    end

    // the update path must never leave two live entries for one pc.
    a_no_dup_pc: assert property (@(posedge clk) disable iff (rst) !dup_pc)
        else $error("btb: duplicate pc in a table");

    a_legal_op: assert property (@(posedge clk) disable iff (rst)
        from_cb.update_en |-> from_cb.fu_opcode inside {BR_COND, BR_JAL, BR_JALR})
        else $error("btb: illegal fu_opcode on update");

endmodule

//--- common/cb_bp_itf.sv
`timescale 1ns/1ps

// training port from commit into the predictor blocks.
interface cb_bp_itf
import bp_pkg::*;
();
    logic        update_en;       // one update per edge, no back-pressure.
    logic        branch_taken;
    br_op_t      fu_opcode;
    logic [31:0] pc;
    logic [31:0] target_address;

    modport cb (
        output update_en,
        output branch_taken,
        output fu_opcode,
        output pc,
        output target_address
    );

    modport bp (
        input  update_en,
        input  branch_taken,
        input  fu_opcode,
        input  pc,
        input  target_address
    );

endinterface

//--- common/bp_pkg.sv
package bp_pkg;

    // selects target table and training rule for an update.
    typedef enum logic [1:0] {
        BR_COND = 2'b00, // conditional branch.
        BR_JAL  = 2'b01,
        BR_JALR = 2'b10
    } br_op_t;

    // one target buffer entry, 65 bits.
    typedef struct packed {
        logic        valid;
        logic [31:0] target_address;
        logic [31:0] pc;
    } btb_entry_t;

endpackage

//--- common/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// instruction slots per fetch block.
`define BP_IF_WIDTH  2

// entries in each of the two target tables.
`define BP_BTB_DEPTH 8
`define BP_BTB_IDX   3

// bimodal counter table.
`define BP_BHT_DEPTH 64
`define BP_BHT_IDX   6

`endif
